//--- logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

   // primary opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_ADDIU   = 6'h09,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } op_e;

   // r-type function field
   typedef enum logic [5:0] {
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_SLT  = 6'h2a
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_LUI
   } alu_op_e;

   // operand source in execute
   typedef enum logic [1:0] {
      FWD_REG,
      FWD_EXMEM,
      FWD_MEMWB
   } fwd_sel_e;

   typedef struct packed {
      op_e         opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  shamt;
      funct_e      funct;
   } r_fmt_t;

   typedef struct packed {
      op_e         opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } i_fmt_t;

   // same 32-bit word, register or immediate layout
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   // sll r0,r0,0 writes nothing
   localparam instr_u nop_instr = '0;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
   import mips_pkg::*;
#(
   parameter int IMEM_DEPTH = 64
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_imem_we,
   input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
   input  logic [31:0]                   i_imem_wdata,
   input  logic                          i_stall,
   input  logic                          i_flush,
   input  logic                          i_take_redirect,
   input  logic [31:0]                   i_redirect_pc,
   output logic [31:0]                   o_pc_plus4,
   output instr_u                        o_instr
);

   localparam int AW = $clog2(IMEM_DEPTH);

   logic [31:0] imem [IMEM_DEPTH];
   logic [31:0] pc;
   logic [31:0] pc_plus4;

   assign pc_plus4 = pc + 32'd4;

   // program load port, only written while the core is in reset
   always_ff @(posedge i_clk) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_wdata;
      end
   end

   // pc and IF/ID latch
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         pc         <= '0;
         o_pc_plus4 <= '0;
         o_instr    <= nop_instr;
      end else if (!i_stall) begin
         // redirect wins over sequential fetch
         pc         <= i_take_redirect ? i_redirect_pc : pc_plus4;
         o_pc_plus4 <= pc_plus4;
         // the word behind a taken branch or jump is dropped
         o_instr    <= i_flush ? nop_instr : instr_u'(imem[pc[AW+1:2]]);
      end
   end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
   import mips_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_pc_plus4,
   input  instr_u      i_instr,
   input  logic        i_bubble,
   input  logic        i_wb_en,
   input  logic [4:0]  i_wb_reg,
   input  logic [31:0] i_wb_data,
   // ID/EX latch
   output logic [31:0] o_rs_val,
   output logic [31:0] o_rt_val,
   output logic [31:0] o_imm,
   output logic [4:0]  o_rs_num,
   output logic [4:0]  o_rt_num,
   output logic [4:0]  o_dst_num,
   output alu_op_e     o_alu_op,
   output logic        o_alu_src_imm,
   output logic        o_mem_read,
   output logic        o_mem_write,
   output logic        o_reg_write,
   // branch and jump resolution
   output logic        o_take_redirect,
   output logic [31:0] o_redirect_pc,
   output logic        o_uses_branch_regs
);

   logic [31:0] rf [32];
   logic [4:0]  rs_num;
   logic [4:0]  rt_num;
   logic [31:0] rs_val;
   logic [31:0] rt_val;
   logic [31:0] sext_imm;
   logic [31:0] imm_ext;
   logic [4:0]  dst_num;
   alu_op_e     alu_op;
   logic        alu_src_imm;
   logic        mem_read;
   logic        mem_write;
   logic        reg_write;
   logic        is_beq;
   logic        is_j;

   assign rs_num   = i_instr.r.rs;
   assign rt_num   = i_instr.r.rt;
   assign sext_imm = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};

   // register file, r0 never written
   always_ff @(posedge i_clk) begin
      if (i_wb_en) begin
         rf[i_wb_reg] <= i_wb_data;
      end
   end

   // same-cycle write is bypassed to the read ports
   assign rs_val = (rs_num == 5'd0) ? 32'd0 :
                   (i_wb_en && i_wb_reg == rs_num) ? i_wb_data : rf[rs_num];
   assign rt_val = (rt_num == 5'd0) ? 32'd0 :
                   (i_wb_en && i_wb_reg == rt_num) ? i_wb_data : rf[rt_num];

   // control decode
   always_comb begin
      dst_num     = i_instr.i.rt;
      imm_ext     = sext_imm;
      alu_op      = ALU_ADD;
      alu_src_imm = 1'b1;
      mem_read    = 1'b0;
      mem_write   = 1'b0;
      reg_write   = 1'b0;
      case (i_instr.r.opcode)
         OP_SPECIAL: begin
            // r view: destination in rd
            dst_num     = i_instr.r.rd;
            alu_src_imm = 1'b0;
            reg_write   = 1'b1;
            case (i_instr.r.funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_SLT:  alu_op = ALU_SLT;
               // unknown funct, incl nop
               default: reg_write = 1'b0;
            endcase
         end
         OP_ADDIU: reg_write = 1'b1;
         OP_ANDI: begin
            imm_ext   = {16'd0, i_instr.i.imm};
            alu_op    = ALU_AND;
            reg_write = 1'b1;
         end
         OP_ORI: begin
            imm_ext   = {16'd0, i_instr.i.imm};
            alu_op    = ALU_OR;
            reg_write = 1'b1;
         end
         OP_LUI: begin
            imm_ext   = {16'd0, i_instr.i.imm};
            alu_op    = ALU_LUI;
            reg_write = 1'b1;
         end
         OP_LW: begin
            mem_read  = 1'b1;
            reg_write = 1'b1;
         end
         OP_SW: mem_write = 1'b1;
         default: ;
      endcase
   end

   // beq compares in decode, j splices pc upper bits
   assign is_beq             = (i_instr.i.opcode == OP_BEQ);
   assign is_j               = (i_instr.i.opcode == OP_J);
   assign o_uses_branch_regs = is_beq;
   assign o_take_redirect    = is_j || (is_beq && rs_val == rt_val);
   assign o_redirect_pc      = is_j ?
      {i_pc_plus4[31:28], i_instr.i.rs, i_instr.i.rt, i_instr.i.imm, 2'b00} :
      i_pc_plus4 + {sext_imm[29:0], 2'b00};

   // ID/EX latch
   always_ff @(posedge i_clk) begin
      o_rs_val      <= rs_val;
      o_rt_val      <= rt_val;
      o_imm         <= imm_ext;
      o_rs_num      <= rs_num;
      o_rt_num      <= rt_num;
      o_alu_src_imm <= alu_src_imm;
      if (!i_rst_n || i_bubble) begin
         // nop controls
         o_dst_num   <= 5'd0;
         o_alu_op    <= ALU_ADD;
         o_mem_read  <= 1'b0;
         o_mem_write <= 1'b0;
         o_reg_write <= 1'b0;
      end else begin
         o_dst_num   <= dst_num;
         o_alu_op    <= alu_op;
         o_mem_read  <= mem_read;
         o_mem_write <= mem_write;
         o_reg_write <= reg_write;
      end
   end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
   import mips_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_rs_val,
   input  logic [31:0] i_rt_val,
   input  logic [31:0] i_imm,
   input  logic [4:0]  i_dst_num,
   input  alu_op_e     i_alu_op,
   input  logic        i_alu_src_imm,
   input  logic        i_mem_read,
   input  logic        i_mem_write,
   input  logic        i_reg_write,
   input  fwd_sel_e    i_fwd_a,
   input  fwd_sel_e    i_fwd_b,
   input  logic [31:0] i_wb_data,
   // EX/MEM latch
   output logic [31:0] o_alu_result,
   output logic [31:0] o_store_data,
   output logic [4:0]  o_dst_num,
   output logic        o_mem_read,
   output logic        o_mem_write,
   output logic        o_reg_write
);

   logic [31:0] opnd_a;
   logic [31:0] fwd_b_val;
   logic [31:0] opnd_b;
   logic [31:0] alu_out;

   // operand a from register, EX/MEM or MEM/WB
   always_comb begin
      case (i_fwd_a)
         FWD_EXMEM: opnd_a = o_alu_result;
         FWD_MEMWB: opnd_a = i_wb_data;
         default:   opnd_a = i_rs_val;
      endcase
   end

   // same for b, before the immediate select
   always_comb begin
      case (i_fwd_b)
         FWD_EXMEM: fwd_b_val = o_alu_result;
         FWD_MEMWB: fwd_b_val = i_wb_data;
         default:   fwd_b_val = i_rt_val;
      endcase
   end

   assign opnd_b = i_alu_src_imm ? i_imm : fwd_b_val;

   always_comb begin
      case (i_alu_op)
         ALU_SUB: alu_out = opnd_a - opnd_b;
         ALU_AND: alu_out = opnd_a & opnd_b;
         ALU_OR:  alu_out = opnd_a | opnd_b;
         // signed compare
         ALU_SLT: alu_out = {31'd0, $signed(opnd_a) < $signed(opnd_b)};
         ALU_LUI: alu_out = {opnd_b[15:0], 16'd0};
         default: alu_out = opnd_a + opnd_b;
      endcase
   end

   always_ff @(posedge i_clk) begin
      o_alu_result <= alu_out;
      // forwarded rt is the store payload
      o_store_data <= fwd_b_val;
      o_dst_num    <= i_dst_num;
      if (!i_rst_n) begin
         o_mem_read  <= 1'b0;
         o_mem_write <= 1'b0;
         o_reg_write <= 1'b0;
      end else begin
         o_mem_read  <= i_mem_read;
         o_mem_write <= i_mem_write;
         // a write to r0 is no write at all
         o_reg_write <= i_reg_write && (i_dst_num != 5'd0);
      end
   end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
   parameter int DMEM_DEPTH = 32
) (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_alu_result,
   input  logic [31:0] i_store_data,
   input  logic [4:0]  i_dst_num,
   input  logic        i_mem_read,
   input  logic        i_mem_write,
   input  logic        i_reg_write,
   // MEM/WB latch, also the register file write port
   output logic        o_wb_en,
   output logic [4:0]  o_wb_reg,
   output logic [31:0] o_wb_data
);

   localparam int DW = $clog2(DMEM_DEPTH);

   logic [31:0]   dmem [DMEM_DEPTH];
   logic [DW-1:0] dmem_addr;
   logic [31:0]   load_data;

   // word address, byte offset ignored
   assign dmem_addr = i_alu_result[DW+1:2];
   assign load_data = dmem[dmem_addr];

   // data memory starts at zero after every reset
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         for (int k = 0; k < DMEM_DEPTH; k++) begin
            dmem[k] <= '0;
         end
      end else if (i_mem_write) begin
         dmem[dmem_addr] <= i_store_data;
      end
   end

   always_ff @(posedge i_clk) begin
      o_wb_reg  <= i_dst_num;
      // load data for lw, alu result otherwise
      o_wb_data <= i_mem_read ? load_data : i_alu_result;
      if (!i_rst_n) begin
         o_wb_en <= 1'b0;
      end else begin
         o_wb_en <= i_reg_write && (i_dst_num != 5'd0);
      end
   end

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
   import mips_pkg::*;
(
   input  logic [4:0] i_if_rs,
   input  logic [4:0] i_if_rt,
   input  logic       i_uses_branch_regs,
   input  logic [4:0] i_ex_dst,
   input  logic       i_ex_reg_write,
   input  logic       i_ex_mem_read,
   input  logic [4:0] i_mem_dst,
   input  logic       i_mem_reg_write,
   input  logic [4:0] i_ex_rs,
   input  logic [4:0] i_ex_rt,
   input  logic       i_wb_en,
   input  logic [4:0] i_wb_reg,
   input  logic       i_take_redirect,
   output fwd_sel_e   o_fwd_a,
   output fwd_sel_e   o_fwd_b,
   output logic       o_stall,
   output logic       o_bubble,
   output logic       o_flush
);

   logic ex_hit;
   logic mem_hit;
   logic load_use;
   logic branch_wait;

   // EX/MEM is the younger result, so it wins
   always_comb begin
      o_fwd_a = FWD_REG;
      o_fwd_b = FWD_REG;
      if (i_mem_reg_write && i_mem_dst != 5'd0 && i_mem_dst == i_ex_rs) begin
         o_fwd_a = FWD_EXMEM;
      end else if (i_wb_en && i_wb_reg != 5'd0 && i_wb_reg == i_ex_rs) begin
         o_fwd_a = FWD_MEMWB;
      end
      if (i_mem_reg_write && i_mem_dst != 5'd0 && i_mem_dst == i_ex_rt) begin
         o_fwd_b = FWD_EXMEM;
      end else if (i_wb_en && i_wb_reg != 5'd0 && i_wb_reg == i_ex_rt) begin
         o_fwd_b = FWD_MEMWB;
      end
   end

   // decode operands produced in ID/EX or EX/MEM
   assign ex_hit  = i_ex_dst != 5'd0 && (i_ex_dst == i_if_rs || i_ex_dst == i_if_rt);
   assign mem_hit = i_mem_dst != 5'd0 && (i_mem_dst == i_if_rs || i_mem_dst == i_if_rt);

   // load result is one cycle too late for execute
   assign load_use = i_ex_mem_read && ex_hit;
   // beq compares in decode, wait for write-back bypass
   assign branch_wait = i_uses_branch_regs &&
                        ((i_ex_reg_write && ex_hit) || (i_mem_reg_write && mem_hit));

   assign o_stall  = load_use || branch_wait;
   assign o_bubble = o_stall;
   // a stalled branch compares stale values, no redirect yet
   assign o_flush  = i_take_redirect && !o_stall;

endmodule

`default_nettype wire

//--- logic/mips_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipe
   import mips_pkg::*;
#(
   parameter int IMEM_DEPTH = 64,
   parameter int DMEM_DEPTH = 32
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_imem_we,
   input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
   input  logic [31:0]                   i_imem_wdata,
   output logic                          o_wb_en,
   output logic [4:0]                    o_wb_reg,
   output logic [31:0]                   o_wb_data
);

   // fetch / decode
   logic [31:0] fet_2_dec_pc_plus4;
   instr_u      fet_2_dec_instr;
   logic [31:0] dec_2_fet_redirect_pc;
   logic        dec_2_fet_take_redirect;
   logic        dec_2_hz_uses_branch_regs;
   // decode / execute
   logic [31:0] dec_2_ex_rs_val;
   logic [31:0] dec_2_ex_rt_val;
   logic [31:0] dec_2_ex_imm;
   logic [4:0]  dec_2_ex_rs_num;
   logic [4:0]  dec_2_ex_rt_num;
   logic [4:0]  dec_2_ex_dst_num;
   alu_op_e     dec_2_ex_alu_op;
   logic        dec_2_ex_alu_src_imm;
   logic        dec_2_ex_mem_read;
   logic        dec_2_ex_mem_write;
   logic        dec_2_ex_reg_write;
   // execute / result
   logic [31:0] ex_2_mem_alu_result;
   logic [31:0] ex_2_mem_store_data;
   logic [4:0]  ex_2_mem_dst_num;
   logic        ex_2_mem_mem_read;
   logic        ex_2_mem_mem_write;
   logic        ex_2_mem_reg_write;
   // write-back, fed back to decode and execute
   logic        wb_en;
   logic [4:0]  wb_reg;
   logic [31:0] wb_data;
   // hazard controls
   fwd_sel_e    hz_2_ex_fwd_a;
   fwd_sel_e    hz_2_ex_fwd_b;
   logic        hz_stall;
   logic        hz_bubble;
   logic        hz_flush;

   assign o_wb_en   = wb_en;
   assign o_wb_reg  = wb_reg;
   assign o_wb_data = wb_data;

   fetch_stage #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) u_fetch (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_imem_we       (i_imem_we),
      .i_imem_addr     (i_imem_addr),
      .i_imem_wdata    (i_imem_wdata),
      .i_stall         (hz_stall),
      .i_flush         (hz_flush),
      .i_take_redirect (dec_2_fet_take_redirect),
      .i_redirect_pc   (dec_2_fet_redirect_pc),
      .o_pc_plus4      (fet_2_dec_pc_plus4),
      .o_instr         (fet_2_dec_instr)
   );

   decode_stage u_decode (
      .i_clk              (i_clk),
      .i_rst_n            (i_rst_n),
      .i_pc_plus4         (fet_2_dec_pc_plus4),
      .i_instr            (fet_2_dec_instr),
      .i_bubble           (hz_bubble),
      .i_wb_en            (wb_en),
      .i_wb_reg           (wb_reg),
      .i_wb_data          (wb_data),
      .o_rs_val           (dec_2_ex_rs_val),
      .o_rt_val           (dec_2_ex_rt_val),
      .o_imm              (dec_2_ex_imm),
      .o_rs_num           (dec_2_ex_rs_num),
      .o_rt_num           (dec_2_ex_rt_num),
      .o_dst_num          (dec_2_ex_dst_num),
      .o_alu_op           (dec_2_ex_alu_op),
      .o_alu_src_imm      (dec_2_ex_alu_src_imm),
      .o_mem_read         (dec_2_ex_mem_read),
      .o_mem_write        (dec_2_ex_mem_write),
      .o_reg_write        (dec_2_ex_reg_write),
      .o_take_redirect    (dec_2_fet_take_redirect),
      .o_redirect_pc      (dec_2_fet_redirect_pc),
      .o_uses_branch_regs (dec_2_hz_uses_branch_regs)
   );

   execute_stage u_execute (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_rs_val      (dec_2_ex_rs_val),
      .i_rt_val      (dec_2_ex_rt_val),
      .i_imm         (dec_2_ex_imm),
      .i_dst_num     (dec_2_ex_dst_num),
      .i_alu_op      (dec_2_ex_alu_op),
      .i_alu_src_imm (dec_2_ex_alu_src_imm),
      .i_mem_read    (dec_2_ex_mem_read),
      .i_mem_write   (dec_2_ex_mem_write),
      .i_reg_write   (dec_2_ex_reg_write),
      .i_fwd_a       (hz_2_ex_fwd_a),
      .i_fwd_b       (hz_2_ex_fwd_b),
      .i_wb_data     (wb_data),
      .o_alu_result  (ex_2_mem_alu_result),
      .o_store_data  (ex_2_mem_store_data),
      .o_dst_num     (ex_2_mem_dst_num),
      .o_mem_read    (ex_2_mem_mem_read),
      .o_mem_write   (ex_2_mem_mem_write),
      .o_reg_write   (ex_2_mem_reg_write)
   );

   result_stage #(
      .DMEM_DEPTH (DMEM_DEPTH)
   ) u_result (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_alu_result (ex_2_mem_alu_result),
      .i_store_data (ex_2_mem_store_data),
      .i_dst_num    (ex_2_mem_dst_num),
      .i_mem_read   (ex_2_mem_mem_read),
      .i_mem_write  (ex_2_mem_mem_write),
      .i_reg_write  (ex_2_mem_reg_write),
      .o_wb_en      (wb_en),
      .o_wb_reg     (wb_reg),
      .o_wb_data    (wb_data)
   );

   // rs/rt of IF/ID straight from the r view
   hazard_unit u_hazard (
      .i_if_rs            (fet_2_dec_instr.r.rs),
      .i_if_rt            (fet_2_dec_instr.r.rt),
      .i_uses_branch_regs (dec_2_hz_uses_branch_regs),
      .i_ex_dst           (dec_2_ex_dst_num),
      .i_ex_reg_write     (dec_2_ex_reg_write),
      .i_ex_mem_read      (dec_2_ex_mem_read),
      .i_mem_dst          (ex_2_mem_dst_num),
      .i_mem_reg_write    (ex_2_mem_reg_write),
      .i_ex_rs            (dec_2_ex_rs_num),
      .i_ex_rt            (dec_2_ex_rt_num),
      .i_wb_en            (wb_en),
      .i_wb_reg           (wb_reg),
      .i_take_redirect    (dec_2_fet_take_redirect),
      .o_fwd_a            (hz_2_ex_fwd_a),
      .o_fwd_b            (hz_2_ex_fwd_b),
      .o_stall            (hz_stall),
      .o_bubble           (hz_bubble),
      .o_flush            (hz_flush)
   );

endmodule

`default_nettype wire

//--- sim/mips_pipe_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_properties (
   input logic        i_clk,
   input logic        i_rst_n,
   input logic        i_wb_en,
   input logic [4:0]  i_wb_reg,
   input logic        i_stall,
   input logic        i_bubble,
   input logic        i_flush,
   input logic [31:0] i_if_pc_plus4
);

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   // write-back quiet right after a reset edge
   a_wb_quiet_after_rst: assert property (@(posedge i_clk) !i_rst_n |=> !i_wb_en)
   else begin
      fail_count++;
      $error("o_wb_en high in the cycle after reset");
   end

   // r0 is never a write target
   a_no_r0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wb_en |-> i_wb_reg != 5'd0)
   else begin
      fail_count++;
      $error("o_wb_en raised with o_wb_reg 0");
   end

   // fetch address of the held IF/ID word frozen under stall
   a_pc_held_on_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_stall |=> $stable(i_if_pc_plus4))
   else begin
      fail_count++;
      $error("fetch pc moved during a stall");
   end

   a_quiet_in_reset: assert property (@(posedge i_clk)
      !i_rst_n |-> !$rose(i_flush) && !$rose(i_bubble))
   else begin
      fail_count++;
      $error("flush or bubble rose while in reset");
   end

endmodule

bind mips_pipe mips_pipe_properties u_props (
   .i_clk         (i_clk),
   .i_rst_n       (i_rst_n),
   .i_wb_en       (o_wb_en),
   .i_wb_reg      (o_wb_reg),
   .i_stall       (hz_stall),
   .i_bubble      (hz_bubble),
   .i_flush       (hz_flush),
   .i_if_pc_plus4 (fet_2_dec_pc_plus4)
);

`default_nettype wire

//--- sim/mips_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mips_checker
   import mips_pkg::*;
#(
   parameter int IMEM_DEPTH = 64,
   parameter int DMEM_DEPTH = 32
) (
   input  logic                          i_clk,
   input  logic                          i_rst_n,
   input  logic                          i_imem_we,
   input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
   input  logic [31:0]                   i_imem_wdata,
   input  logic                          i_wb_en,
   input  logic [4:0]                    i_wb_reg,
   input  logic [31:0]                   i_wb_data,
   output logic                          o_done,
   output int                            o_value_errs,
   output int                            o_extra_errs,
   output int                            o_model_errs
);

   logic [31:0] prog [IMEM_DEPTH];
   logic [31:0] regs [32];
   logic [31:0] dmem [DMEM_DEPTH];
   // expected register writes, program order
   logic [4:0]  exp_reg [$];
   logic [31:0] exp_data [$];
   logic        model_ready;
   int          seen;
   int          value_errs;
   int          extra_errs;
   int          model_errs;

   // instruction-level run from pc 0 to the closing self-jump
   task automatic run_model();
      instr_u      ins;
      logic [31:0] pc;
      logic [31:0] npc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sext;
      logic [31:0] zext;
      logic [31:0] res;
      logic [4:0]  dst;
      logic        wr;
      logic        stop;
      int          steps;
      exp_reg.delete();
      exp_data.delete();
      for (int k = 0; k < 32; k++) regs[k] = '0;
      for (int k = 0; k < DMEM_DEPTH; k++) dmem[k] = '0;
      pc    = '0;
      stop  = 1'b0;
      steps = 0;
      while (!stop && steps < 4 * IMEM_DEPTH) begin
         ins  = prog[int'(pc >> 2) % IMEM_DEPTH];
         a    = regs[ins.r.rs];
         b    = regs[ins.r.rt];
         sext = {{16{ins.i.imm[15]}}, ins.i.imm};
         zext = {16'd0, ins.i.imm};
         npc  = pc + 32'd4;
         dst  = ins.i.rt;
         res  = '0;
         wr   = 1'b0;
         case (ins.r.opcode)
            OP_SPECIAL: begin
               dst = ins.r.rd;
               wr  = 1'b1;
               case (ins.r.funct)
                  FN_ADDU: res = a + b;
                  FN_SUBU: res = a - b;
                  FN_AND:  res = a & b;
                  FN_OR:   res = a | b;
                  FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            OP_ADDIU: begin
               res = a + sext;
               wr  = 1'b1;
            end
            OP_ANDI: begin
               res = a & zext;
               wr  = 1'b1;
            end
            OP_ORI: begin
               res = a | zext;
               wr  = 1'b1;
            end
            OP_LUI: begin
               res = {ins.i.imm, 16'd0};
               wr  = 1'b1;
            end
            // word addressed, wraps at the memory size
            OP_LW: begin
               res = dmem[int'((a + sext) >> 2) % DMEM_DEPTH];
               wr  = 1'b1;
            end
            OP_SW: dmem[int'((a + sext) >> 2) % DMEM_DEPTH] = b;
            OP_BEQ: begin
               if (a == b) npc = pc + 32'd4 + (sext << 2);
            end
            OP_J: begin
               npc  = {npc[31:28], ins[25:0], 2'b00};
               stop = (npc == pc);
            end
            default: ;
         endcase
         if (wr && dst != 5'd0) begin
            regs[dst] = res;
            exp_reg.push_back(dst);
            exp_data.push_back(res);
         end
         pc = npc;
         steps++;
      end
      if (!stop) begin
         model_errs++;
         $display("model never reached the closing self-jump in %0d steps", steps);
      end
   endtask

   // one observed write against the next predicted one
   task automatic compare_write();
      if (seen >= exp_reg.size()) begin
         extra_errs++;
         $display("%0t: unexpected register write r%0d = %h after the last expected write",
                  $time, i_wb_reg, i_wb_data);
      end else begin
         if (i_wb_reg !== exp_reg[seen]) begin
            value_errs++;
            $display("ERROR at %0t: o_wb_reg expected %0d, actual %0d",
                     $time, exp_reg[seen], i_wb_reg);
         end
         if (i_wb_data !== exp_data[seen]) begin
            value_errs++;
            $display("ERROR at %0t: o_wb_data expected %h, actual %h",
                     $time, exp_data[seen], i_wb_data);
         end
         seen++;
      end
   endtask

   initial begin
      model_ready = 1'b0;
      seen        = 0;
      value_errs  = 0;
      extra_errs  = 0;
      model_errs  = 0;
   end

   always @(posedge i_clk) begin
      if (!i_rst_n) begin
         // program comes in through the load port
         if (i_imem_we) prog[i_imem_addr] = i_imem_wdata;
         model_ready = 1'b0;
         seen        = 0;
      end else begin
         if (!model_ready) begin
            run_model();
            model_ready = 1'b1;
         end
         if (i_wb_en) compare_write();
      end
      o_done       <= model_ready && (seen == exp_reg.size());
      o_value_errs <= value_errs;
      o_extra_errs <= extra_errs;
      o_model_errs <= model_errs;
   end

endmodule

`default_nettype wire

//--- sim/tb_mips_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipe #(
   parameter int SEED    = 32'h775b21eb,
   parameter int TIMEOUT = 5000
);
   import mips_pkg::*;

   localparam int IMEM_DEPTH = 64;
   localparam int DMEM_DEPTH = 32;
   localparam int AW         = $clog2(IMEM_DEPTH);
   localparam int BODY_LEN   = 40;
   // index of the closing self-jump
   localparam int END_IDX    = 7 + BODY_LEN;

   logic          clk;
   logic          rst_n;
   logic          imem_we;
   logic [AW-1:0] imem_addr;
   logic [31:0]   imem_wdata;
   logic          wb_en;
   logic [4:0]    wb_reg;
   logic [31:0]   wb_data;
   logic          model_done;
   int            value_errs;
   int            extra_errs;
   int            model_errs;
   int            assert_errs;
   int            timeout_errs;
   int            seed;
   int            cycles;
   logic [31:0]   prog [IMEM_DEPTH];

   mips_pipe #(
      .IMEM_DEPTH (IMEM_DEPTH),
      .DMEM_DEPTH (DMEM_DEPTH)
   ) dut0 (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_imem_we    (imem_we),
      .i_imem_addr  (imem_addr),
      .i_imem_wdata (imem_wdata),
      .o_wb_en      (wb_en),
      .o_wb_reg     (wb_reg),
      .o_wb_data    (wb_data)
   );

   mips_checker #(
      .IMEM_DEPTH (IMEM_DEPTH),
      .DMEM_DEPTH (DMEM_DEPTH)
   ) u_checker (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_imem_we    (imem_we),
      .i_imem_addr  (imem_addr),
      .i_imem_wdata (imem_wdata),
      .i_wb_en      (wb_en),
      .i_wb_reg     (wb_reg),
      .i_wb_data    (wb_data),
      .o_done       (model_done),
      .o_value_errs (value_errs),
      .o_extra_errs (extra_errs),
      .o_model_errs (model_errs)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic int pick(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic logic [31:0] r_word(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd);
      return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] i_word(op_e op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jump_word(int idx);
      return {OP_J, 26'(idx)};
   endfunction

   // r1-r7 seeded, random body over r0-r7, self-jump at the end
   task automatic build_program();
      int          n;
      int          off;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [4:0]  rd;
      logic [15:0] imm;
      n = 0;
      for (int r = 1; r <= 7; r++) begin
         prog[n] = i_word(OP_ADDIU, 5'd0, 5'(r), 16'(pick(65536)));
         n++;
      end
      while (n < END_IDX) begin
         ra  = 5'(pick(8));
         rb  = 5'(pick(8));
         rd  = 5'(pick(8));
         imm = 16'(pick(65536));
         case (pick(13))
            0: prog[n] = r_word(FN_ADDU, ra, rb, rd);
            1: prog[n] = r_word(FN_SUBU, ra, rb, rd);
            2: prog[n] = r_word(FN_AND, ra, rb, rd);
            3: prog[n] = r_word(FN_OR, ra, rb, rd);
            4: prog[n] = r_word(FN_SLT, ra, rb, rd);
            5: prog[n] = i_word(OP_ADDIU, ra, rb, imm);
            6: prog[n] = i_word(OP_ANDI, ra, rb, imm);
            7: prog[n] = i_word(OP_ORI, ra, rb, imm);
            8: prog[n] = i_word(OP_LUI, 5'd0, rb, imm);
            9: prog[n] = i_word(OP_LW, 5'd0, rb, 16'(pick(DMEM_DEPTH) * 4));
            10: prog[n] = i_word(OP_SW, 5'd0, rb, 16'(pick(DMEM_DEPTH) * 4));
            11: begin
               // forward 1 to 3, never past the self-jump
               off = 1 + pick(3);
               if (off > END_IDX - n - 1) off = END_IDX - n - 1;
               // equal operands half the time, so taken often
               if (pick(2) == 0) rb = ra;
               prog[n] = i_word(OP_BEQ, ra, rb, 16'(off));
            end
            default: begin
               if (n + 3 <= END_IDX) begin
                  // store, reload, use right away
                  rb  = 5'(1 + pick(7));
                  imm = 16'(pick(DMEM_DEPTH) * 4);
                  prog[n] = i_word(OP_SW, 5'd0, ra, imm);
                  n++;
                  prog[n] = i_word(OP_LW, 5'd0, rb, imm);
                  n++;
                  prog[n] = r_word(FN_ADDU, rb, ra, rd);
               end else begin
                  prog[n] = r_word(FN_ADDU, ra, rb, rd);
               end
            end
         endcase
         n++;
      end
      // unused words each jump to themselves
      for (int k = END_IDX; k < IMEM_DEPTH; k++) prog[k] = jump_word(k);
   endtask

   task automatic load_program();
      for (int k = 0; k < IMEM_DEPTH; k++) begin
         @(posedge clk);
         imem_we    <= 1'b1;
         imem_addr  <= AW'(k);
         imem_wdata <= prog[k];
      end
      @(posedge clk);
      imem_we <= 1'b0;
   endtask

   initial begin
      seed         = SEED;
      rst_n        = 1'b0;
      imem_we      = 1'b0;
      imem_addr    = '0;
      imem_wdata   = '0;
      timeout_errs = 0;
      build_program();
      repeat (4) @(posedge clk);
      load_program();
      @(posedge clk);
      rst_n <= 1'b1;
      cycles = 0;
      while (!model_done && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (!model_done) begin
         timeout_errs++;
         $display("timeout: not all expected register writes seen after %0d cycles", cycles);
      end else begin
         // catch any write past the self-loop
         repeat (20) @(posedge clk);
      end
      assert_errs = dut0.u_props.fail_count;
      $display("errors: value %0d, extra writes %0d, model %0d, assertions %0d, timeouts %0d",
               value_errs, extra_errs, model_errs, assert_errs, timeout_errs);
      if (value_errs + extra_errs + model_errs + assert_errs + timeout_errs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mips_pipe.f
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/hazard_unit.sv
logic/mips_pipe.sv
sim/mips_pipe_properties.sv
sim/mips_checker.sv
sim/tb_mips_pipe.sv

//--- Makefile
# Verilator build and run for the pipelined MIPS core
VERILATOR ?= verilator
TOP       ?= tb_mips_pipe
FILELIST  ?= mips_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
# 2002461163 is 0x775b21eb
SEED      ?= 2002461163
TIMEOUT   ?= 5000
# let every assertion failure reach the final report
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG SEED TIMEOUT SIM_ARGS"

test:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -GSEED=$(SEED) -GTIMEOUT=$(TIMEOUT) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
